// ==== logic/boot_reset_ctrl.sv ====
`timescale 1ns/1ps
`include "nes_params.svh"

module boot_reset_ctrl (
  input  logic clk_ppu_21_47,
  input  logic reset_nes,
  input  logic download,
  input  logic loader_busy,
  input  logic loader_done,
  input  logic loader_fail,
  input  logic [`NES_FLAGS_W-1:0] loader_flags,
  output logic core_reset,
  output logic loader_reset,
  output logic loader_owns_bus,
  output logic [`NES_FLAGS_W-1:0] mapper_flags,
  output logic has_save
);

  typedef enum logic [1:0] {
    hold_boot,
    loading,
    draining,
    running
  } state_e;

  state_e state;
  logic [7:0] drain_cnt;
  logic download_prev;
  logic drain_last;

  // last non-busy edge of the drain
  assign drain_last = (drain_cnt == 8'd1) && !loader_busy;

  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      state <= hold_boot;
      drain_cnt <= 8'd0;
      download_prev <= 1'b0;
      loader_reset <= 1'b1;
    end else begin
      download_prev <= download;
      // one cycle pulse after download rises
      loader_reset <= download && !download_prev;
      if (download) begin
        // any download restarts the sequence
        state <= loading;
        drain_cnt <= 8'(`NES_DOWNLOAD_RESET_CYCLES);
      end else begin
        if (!loader_busy && drain_cnt != 8'd0) begin
          drain_cnt <= drain_cnt - 8'd1;
        end
        unique case (state)
          loading:  state <= draining;
          draining: if (drain_last) state <= running;
          default:  state <= state;
        endcase
      end
    end
  end

  // core held until the drain is over, failure overrides at once
  assign core_reset = (state != running) || loader_fail;

  // no bus grant before the first download
  assign loader_owns_bus = (state != hold_boot) && (download || loader_busy);

  // flags must read 0 until a load completes
  always_ff @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      mapper_flags <= '0;
    end else if (loader_done) begin
      mapper_flags <= loader_flags;
    end
  end

  assign has_save = mapper_flags[`NES_HAS_SAVE_BIT];

endmodule

// ==== logic/joypad_serializer.sv ====
`timescale 1ns/1ps
`include "nes_params.svh"

module joypad_serializer (
  input  logic clk_ppu_21_47,
  input  logic core_reset,
  input  logic multitap,
  input  nes_input_pkg::pad_buttons_t pads [4],
  input  nes_input_pkg::joy_bus_t joy,
  output logic [1:0] joy_data
);

  import nes_input_pkg::*;

  logic [23:0] shift_q [2];
  logic [23:0] load_val [2];
  logic [1:0] read_clk_prev;
  logic [1:0] shift_en;

  // low byte is the local pad, upper bytes the adapter frame or filler
  always_comb begin
    load_val[0] = {multitap ? {`NES_SIG_PORT1, pads[2]} : 16'hffff, pads[0]};
    load_val[1] = {multitap ? {`NES_SIG_PORT2, pads[3]} : 16'hffff, pads[1]};
  end

  // falling read clock per port
  assign shift_en = read_clk_prev & ~joy.read_clk;

  always_ff @(posedge clk_ppu_21_47) begin
    if (core_reset) begin
      shift_q[0] <= '0;
      shift_q[1] <= '0;
      read_clk_prev <= 2'b00;
    end else begin
      read_clk_prev <= joy.read_clk;
      for (int p = 0; p < 2; p++) begin
        // shift of the old word wins over a strobe on the same edge
        if (shift_en[p]) begin
          shift_q[p] <= {1'b0, shift_q[p][23:1]};
        end else if (joy.strobe) begin
          shift_q[p] <= load_val[p];
        end
      end
    end
  end

  // serial bit seen by the console
  assign joy_data = {shift_q[1][0], shift_q[0][0]};

endmodule

// ==== logic/mem_channel_router.sv ====
`timescale 1ns/1ps
`include "nes_params.svh"

module mem_channel_router (
  input  logic clk_ppu_21_47,
  input  logic reset_nes,
  input  logic loader_owns_bus,
  input  nes_mem_pkg::mem_req_t loader_req,
  input  nes_mem_pkg::mem_req_t ppu_req,
  input  logic save_wr,
  input  logic save_rd,
  input  logic [`NES_SAVE_ADDR_W-1:0] save_addr,
  input  logic [7:0] save_wdata,
  input  logic ch2_busy,
  input  logic [7:0] ch0_rdata,
  input  logic [7:0] ch2_rdata,
  output nes_mem_pkg::mem_req_t ch0_req,
  output nes_mem_pkg::mem_req_t ch2_req,
  output logic [7:0] ppu_rdata,
  output logic [7:0] save_rdata
);

  import nes_mem_pkg::*;

  mem_req_t ch0_next;
  mem_req_t ch2_next;

  // loader has channel 0 during a load, ppu traffic is dropped then
  assign ch0_next = loader_owns_bus ? loader_req : ppu_req;

  // save buffer goes to channel 2 inside the save window
  always_comb begin
    ch2_next.addr = {`NES_SAVE_BASE, save_addr};
    ch2_next.wdata = save_wdata;
    // a busy channel drops the request, the buffer retries
    if (ch2_busy) begin
      ch2_next.op = op_idle;
    end else if (save_wr) begin
      ch2_next.op = op_write;
    end else if (save_rd) begin
      ch2_next.op = op_read;
    end else begin
      ch2_next.op = op_idle;
    end
  end

  // one register stage towards the memory side
  always_ff @(posedge clk_ppu_21_47) begin
    ch0_req <= ch0_next;
    ch2_req <= ch2_next;
    if (reset_nes) begin
      ch0_req.op <= op_idle;
      ch2_req.op <= op_idle;
    end
  end

  // read data comes straight back
  assign ppu_rdata = ch0_rdata;
  assign save_rdata = ch2_rdata;

endmodule

// ==== logic/nes_board.sv ====
`timescale 1ns/1ps
`include "nes_params.svh"

module nes_board (
  input  logic clk_ppu_21_47,
  input  logic reset_nes,
  // cartridge loader
  input  logic download,
  input  logic loader_busy,
  input  logic loader_done,
  input  logic loader_fail,
  input  logic [`NES_FLAGS_W-1:0] loader_flags,
  input  nes_mem_pkg::mem_req_t loader_req,
  output logic loader_reset,
  // console core
  input  nes_mem_pkg::mem_req_t ppu_req,
  output logic [7:0] ppu_rdata,
  input  nes_input_pkg::joy_bus_t joy,
  output logic [1:0] joy_data,
  output logic core_reset,
  // controllers
  input  logic multitap,
  input  nes_input_pkg::pad_buttons_t pads [4],
  // save buffer
  input  logic save_wr,
  input  logic save_rd,
  input  logic [`NES_SAVE_ADDR_W-1:0] save_addr,
  input  logic [7:0] save_wdata,
  output logic [7:0] save_rdata,
  output logic has_save,
  // memory side
  output nes_mem_pkg::mem_req_t ch0_req,
  output nes_mem_pkg::mem_req_t ch2_req,
  input  logic [7:0] ch0_rdata,
  input  logic [7:0] ch2_rdata,
  input  logic ch2_busy
);

  logic loader_owns_bus;

  boot_reset_ctrl u_boot_reset_ctrl (
    .clk_ppu_21_47   (clk_ppu_21_47),
    .reset_nes       (reset_nes),
    .download        (download),
    .loader_busy     (loader_busy),
    .loader_done     (loader_done),
    .loader_fail     (loader_fail),
    .loader_flags    (loader_flags),
    .core_reset      (core_reset),
    .loader_reset    (loader_reset),
    .loader_owns_bus (loader_owns_bus),
    // only the save bit leaves the board
    .mapper_flags    (),
    .has_save        (has_save)
  );

  joypad_serializer u_joypad_serializer (
    .clk_ppu_21_47 (clk_ppu_21_47),
    .core_reset    (core_reset),
    .multitap      (multitap),
    .pads          (pads),
    .joy           (joy),
    .joy_data      (joy_data)
  );

  mem_channel_router u_mem_channel_router (
    .clk_ppu_21_47   (clk_ppu_21_47),
    .reset_nes       (reset_nes),
    .loader_owns_bus (loader_owns_bus),
    .loader_req      (loader_req),
    .ppu_req         (ppu_req),
    .save_wr         (save_wr),
    .save_rd         (save_rd),
    .save_addr       (save_addr),
    .save_wdata      (save_wdata),
    .ch2_busy        (ch2_busy),
    .ch0_rdata       (ch0_rdata),
    .ch2_rdata       (ch2_rdata),
    .ch0_req         (ch0_req),
    .ch2_req         (ch2_req),
    .ppu_rdata       (ppu_rdata),
    .save_rdata      (save_rdata)
  );

endmodule

// ==== logic/nes_input_pkg.sv ====
package nes_input_pkg;

  // one standard pad
  // bit order matches the serial order read by the console, a first
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } pad_buttons_t;

  // controller port lines driven by the core
  typedef struct packed {
    // latch request, loads both ports
    logic strobe;
    // one read clock per port, port 1 in bit 0
    logic [1:0] read_clk;
  } joy_bus_t;

endpackage

// ==== logic/nes_mem_pkg.sv ====
`include "nes_params.svh"

package nes_mem_pkg;

  // operation carried by a request
  // a request is only valid while op is not idle
  typedef enum logic [1:0] {
    op_idle  = 2'd0,
    op_read  = 2'd1,
    op_write = 2'd2
  } mem_op_e;

  // one byte wide sdram request
  typedef struct packed {
    logic [`NES_ADDR_W-1:0] addr;
    logic [7:0] wdata;
    mem_op_e op;
  } mem_req_t;

endpackage

// ==== logic/nes_params.svh ====
`ifndef NES_PARAMS_SVH
`define NES_PARAMS_SVH

// non-busy cycles of reset after a download ends
`define NES_DOWNLOAD_RESET_CYCLES 255

// sdram byte address
`define NES_ADDR_W 25

// save buffer address, placed under the window base
`define NES_SAVE_ADDR_W 18
`define NES_SAVE_BASE 7'b0001111

// mapper flags from the loader
`define NES_FLAGS_W 64
// battery backed ram present
`define NES_HAS_SAVE_BIT 25

// four-player adapter signature bytes
`define NES_SIG_PORT1 8'h08
`define NES_SIG_PORT2 8'h04

`endif

// ==== sim/tb_nes_board.sv ====
`timescale 1ns/1ps
`include "nes_params.svh"

module tb_nes_board;

  import nes_input_pkg::*;
  import nes_mem_pkg::*;

  logic clk_ppu_21_47;
  logic reset_nes;
  logic download, loader_busy, loader_done, loader_fail;
  logic [`NES_FLAGS_W-1:0] loader_flags;
  mem_req_t loader_req, ppu_req, ch0_req, ch2_req;
  logic loader_reset, core_reset, has_save, multitap;
  logic [7:0] ppu_rdata, save_rdata, ch0_rdata, ch2_rdata, save_wdata;
  joy_bus_t joy;
  logic [1:0] joy_data;
  pad_buttons_t pads [4];
  logic save_wr, save_rd, ch2_busy;
  logic [`NES_SAVE_ADDR_W-1:0] save_addr;

  integer seed;
  int checks, errors, test_errors;

  // reference model state
  logic m_loaded;
  int m_nonbusy;
  logic m_dl_prev, m_loader_reset;
  logic [`NES_FLAGS_W-1:0] m_flags;
  mem_req_t m_ch0, m_ch2;
  logic m_core_reset, m_owns;

  nes_board dut0 (.*);

  initial clk_ppu_21_47 = 1'b0;
  always #20 clk_ppu_21_47 = ~clk_ppu_21_47;

  // core runs once a download finished and 255 idle loader edges passed
  assign m_core_reset = loader_fail ||
                        !(m_loaded && m_nonbusy == `NES_DOWNLOAD_RESET_CYCLES);
  assign m_owns = m_loaded && (download || loader_busy);

  always @(posedge clk_ppu_21_47) begin
    if (reset_nes) begin
      m_loaded <= 1'b0;
      m_nonbusy <= 0;
      m_dl_prev <= 1'b0;
      m_loader_reset <= 1'b1;
      m_flags <= '0;
    end else begin
      m_dl_prev <= download;
      m_loader_reset <= download && !m_dl_prev;
      if (download) begin
        m_loaded <= 1'b1;
        m_nonbusy <= 0;
      end else if (m_loaded && !loader_busy && m_nonbusy < `NES_DOWNLOAD_RESET_CYCLES) begin
        m_nonbusy <= m_nonbusy + 1;
      end
      if (loader_done) begin
        m_flags <= loader_flags;
      end
    end
    m_ch0 <= m_owns ? loader_req : ppu_req;
    m_ch2.addr <= {`NES_SAVE_BASE, save_addr};
    m_ch2.wdata <= save_wdata;
    if (reset_nes || ch2_busy || !(save_wr || save_rd)) begin
      m_ch2.op <= op_idle;
    end else if (save_wr) begin
      m_ch2.op <= op_write;
    end else begin
      m_ch2.op <= op_read;
    end
    if (reset_nes) begin
      m_ch0.op <= op_idle;
    end
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("MISMATCH %s got %0h expected %0h", name, got, exp);
    end
  endtask

  task automatic check_board();
    check("core_reset", core_reset, m_core_reset);
    check("loader_reset", loader_reset, m_loader_reset);
    check("has_save", has_save, m_flags[`NES_HAS_SAVE_BIT]);
    check("ch0_req.op", ch0_req.op, m_ch0.op);
    if (m_ch0.op != op_idle) begin
      check("ch0_req.addr", ch0_req.addr, m_ch0.addr);
      check("ch0_req.wdata", ch0_req.wdata, m_ch0.wdata);
    end
    check("ch2_req.op", ch2_req.op, m_ch2.op);
    if (m_ch2.op != op_idle) begin
      check("ch2_req.addr", ch2_req.addr, m_ch2.addr);
      check("ch2_req.wdata", ch2_req.wdata, m_ch2.wdata);
    end
    check("ppu_rdata", ppu_rdata, ch0_rdata);
    check("save_rdata", save_rdata, ch2_rdata);
  endtask

  task automatic finish_test(input int num, input string name);
    $display("test %0d %s: %s", num, name, (test_errors == 0) ? "passed" : "failed");
    test_errors = 0;
  endtask

  function automatic mem_req_t rand_req();
    logic [31:0] r;
    mem_req_t req;
    r = $random(seed);
    req.addr = r[`NES_ADDR_W-1:0];
    r = $random(seed);
    req.wdata = r[7:0];
    req.op = (r[9:8] == 2'd3) ? op_idle : mem_op_e'(r[9:8]);
    return req;
  endfunction

  // serial bit on a port after n falling read clocks
  function automatic logic bit_after(input logic [23:0] word, input int n);
    return (n < 24) ? word[n] : 1'b0;
  endfunction

  function automatic logic [23:0] port_word(input logic mt, input pad_buttons_t own,
                                            input pad_buttons_t extra, input logic [7:0] sig);
    logic [15:0] upper;
    upper = mt ? {sig, extra} : 16'hffff;
    return {upper, own};
  endfunction

  task automatic drive_bus();
    logic [31:0] r;
    loader_req <= rand_req();
    ppu_req <= rand_req();
    r = $random(seed);
    ch0_rdata <= r[7:0];
    ch2_rdata <= r[15:8];
  endtask

  initial begin
    int i, k, p, mt, dl_len, nonbusy, pulses;
    logic [31:0] r32;
    logic [23:0] words [2];
    int shifts [2];
    seed = 32'h5f60_c445;
    checks = 0;
    errors = 0;
    test_errors = 0;
    reset_nes = 1'b1;
    download = 1'b0;
    loader_busy = 1'b0;
    loader_done = 1'b0;
    loader_fail = 1'b0;
    loader_flags = '0;
    loader_req = '0;
    ppu_req = '0;
    joy = '0;
    multitap = 1'b0;
    for (i = 0; i < 4; i++) begin
      pads[i] = '0;
    end
    save_wr = 1'b0;
    save_rd = 1'b0;
    save_addr = '0;
    save_wdata = '0;
    ch0_rdata = '0;
    ch2_rdata = '0;
    ch2_busy = 1'b0;
    repeat (4) @(posedge clk_ppu_21_47);
    reset_nes <= 1'b0;

    // core held before any download
    for (i = 0; i < 100; i++) begin
      @(posedge clk_ppu_21_47);
      drive_bus();
      loader_flags <= {$random(seed), $random(seed)};
      r32 = $random(seed);
      loader_busy <= r32[0];
      @(negedge clk_ppu_21_47);
      check_board();
      check("core_reset before download", core_reset, 1'b1);
      check("has_save before download", has_save, 1'b0);
    end
    finish_test(1, "boot hold");

    // download followed by a drain with random busy gaps
    pulses = 0;
    @(posedge clk_ppu_21_47);
    download <= 1'b1;
    r32 = $random(seed);
    dl_len = 2 + r32[4:0];
    for (i = 0; i < dl_len; i++) begin
      drive_bus();
      @(negedge clk_ppu_21_47);
      check_board();
      pulses += loader_reset;
      @(posedge clk_ppu_21_47);
    end
    download <= 1'b0;
    r32 = $random(seed);
    loader_busy <= (r32[1:0] == 2'd0);
    nonbusy = 0;
    for (i = 0; i < 2000 && core_reset; i++) begin
      @(posedge clk_ppu_21_47);
      // this edge samples the busy level driven one cycle earlier
      if (!loader_busy) begin
        nonbusy++;
      end
      drive_bus();
      r32 = $random(seed);
      loader_busy <= (r32[1:0] == 2'd0);
      @(negedge clk_ppu_21_47);
      check_board();
      check("core_reset during drain", core_reset, nonbusy < `NES_DOWNLOAD_RESET_CYCLES);
      pulses += loader_reset;
    end
    if (core_reset) begin
      $display("timeout: core_reset still high after 2000 cycles of drain");
      errors++;
      test_errors++;
    end
    check("drain edges", nonbusy, `NES_DOWNLOAD_RESET_CYCLES);
    check("loader_reset pulses", pulses, 1);
    @(posedge clk_ppu_21_47);
    loader_busy <= 1'b0;
    loader_fail <= 1'b1;
    @(negedge clk_ppu_21_47);
    check_board();
    check("core_reset on loader_fail", core_reset, 1'b1);
    @(posedge clk_ppu_21_47);
    loader_fail <= 1'b0;
    @(negedge clk_ppu_21_47);
    check_board();
    finish_test(2, "download reset sequence");

    // flags latch on loader_done only
    for (i = 0; i < 40; i++) begin
      @(posedge clk_ppu_21_47);
      loader_flags <= {$random(seed), $random(seed)};
      r32 = $random(seed);
      loader_done <= (i == 20) || (r32[2:0] == 3'd0);
      @(negedge clk_ppu_21_47);
      check_board();
    end
    @(posedge clk_ppu_21_47);
    loader_done <= 1'b0;
    finish_test(3, "mapper flags");

    // controller ports with multitap off and then on
    for (mt = 0; mt < 2; mt++) begin
      @(posedge clk_ppu_21_47);
      multitap <= mt[0];
      for (i = 0; i < 4; i++) begin
        r32 = $random(seed);
        pads[i] <= r32[7:0];
      end
      joy.strobe <= 1'b1;
      @(posedge clk_ppu_21_47);
      joy.strobe <= 1'b0;
      @(negedge clk_ppu_21_47);
      words[0] = port_word(mt[0], pads[0], pads[2], `NES_SIG_PORT1);
      words[1] = port_word(mt[0], pads[1], pads[3], `NES_SIG_PORT2);
      shifts[0] = 0;
      shifts[1] = 0;
      check("joy_data", joy_data, {words[1][0], words[0][0]});
      // ports take turns so each one is seen holding while the other shifts
      for (k = 1; k <= 24; k++) begin
        for (p = 0; p < 2; p++) begin
          @(posedge clk_ppu_21_47);
          joy.read_clk[p] <= 1'b1;
          @(posedge clk_ppu_21_47);
          joy.read_clk[p] <= 1'b0;
          @(posedge clk_ppu_21_47);
          @(negedge clk_ppu_21_47);
          shifts[p] = k;
          check("joy_data", joy_data,
                {bit_after(words[1], shifts[1]), bit_after(words[0], shifts[0])});
        end
      end
    end
    finish_test(4, "controller serialization");

    // channel 0 owned by the loader and then by the ppu
    @(posedge clk_ppu_21_47);
    download <= 1'b1;
    for (i = 0; i < 60; i++) begin
      if (i == 30) begin
        download <= 1'b0;
      end
      drive_bus();
      @(negedge clk_ppu_21_47);
      check_board();
      @(posedge clk_ppu_21_47);
    end
    finish_test(5, "channel 0 routing");

    // save requests under random busy
    for (i = 0; i < 80; i++) begin
      @(posedge clk_ppu_21_47);
      r32 = $random(seed);
      save_wr <= r32[0];
      save_rd <= r32[1];
      ch2_busy <= (r32[3:2] == 2'd0);
      save_wdata <= r32[15:8];
      ch2_rdata <= r32[23:16];
      r32 = $random(seed);
      save_addr <= r32[`NES_SAVE_ADDR_W-1:0];
      @(negedge clk_ppu_21_47);
      check_board();
    end
    finish_test(6, "save channel routing");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+logic
logic/nes_input_pkg.sv
logic/nes_mem_pkg.sv
logic/boot_reset_ctrl.sv
logic/joypad_serializer.sv
logic/mem_channel_router.sv
logic/nes_board.sv
sim/tb_nes_board.sv
